//--- hdl/mm_ram_pkg.sv
// ##############################
// memory map, status codes and shared types of the RAM wrapper
// all peripheral registers are one 32-bit word wide
// ##############################

package mm_ram_pkg;

  // timer registers, write only
  localparam logic [31:0] TIMER_MASK_ADDR = 32'h1500_0000;
  localparam logic [31:0] TIMER_CNT_ADDR  = 32'h1500_0004;

  // readable peripheral word, always reads as zero
  localparam logic [31:0] PERIPH_RD_ADDR  = 32'h1500_1000;

  // test status and exit registers, write only
  localparam logic [31:0] STATUS_ADDR     = 32'h2000_0000;
  localparam logic [31:0] EXIT_ADDR       = 32'h2000_0004;

  // values written to the status register
  localparam logic [31:0] PASS_CODE       = 32'd123456789;
  localparam logic [31:0] FAIL_CODE       = 32'd1;

  // mask bit of the timer and id expected with the acknowledge
  localparam logic [4:0]  TIMER_IRQ_ID    = 5'd7;

  // where an accepted data request went
  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_ERR    = 2'd2
  } target_e;

  // data port request after decoding, only valid in the RAM range
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    // only the low RAM address bits reach the array
    logic [31:0] addr;
    logic [31:0] wdata;
  } ram_req_t;

  // one write strobe per timer register, shared data word
  typedef struct packed {
    logic        mask_we;
    logic        cnt_we;
    logic [31:0] wdata;
  } timer_wr_t;

endpackage

//--- hdl/dp_ram.sv
// ##############################
// contents are not reset; both ports align to 4 bytes
// instruction bytes past the top of the array wrap to address zero
// ##############################

`timescale 1ns/1ps

module dp_ram #(
  parameter int RAM_ADDR_WIDTH    = 16,
  parameter int INSTR_RDATA_WIDTH = 128
) (
  input  logic                         clk_i,

  // instruction port, read only
  input  logic                         instr_req_i,
  input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
  output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

  // data port, read and byte-enabled write
  input  mm_ram_pkg::ram_req_t         ram_req_i,
  output logic [31:0]                  data_rdata_o
);

  localparam int RAM_BYTES   = 2 ** RAM_ADDR_WIDTH;
  localparam int INSTR_BYTES = INSTR_RDATA_WIDTH / 8;

  logic [7:0] mem [RAM_BYTES];

  logic [RAM_ADDR_WIDTH-1:0] instr_base;
  logic [RAM_ADDR_WIDTH-1:0] data_base;

  // drop the byte offset on both ports
  assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};
  assign data_base  = {ram_req_i.addr[RAM_ADDR_WIDTH-1:2], 2'b00};

  // wide fetch, the index sum is RAM_ADDR_WIDTH bits so it wraps
  always_ff @(posedge clk_i) begin
    if (instr_req_i) begin
      for (int i = 0; i < INSTR_BYTES; i++) begin
        instr_rdata_o[8*i +: 8] <= mem[instr_base + RAM_ADDR_WIDTH'(i)];
      end
    end
  end

  // read sees the old word when a write hits the same edge
  always_ff @(posedge clk_i) begin
    if (ram_req_i.req) begin
      for (int j = 0; j < 4; j++) begin
        data_rdata_o[8*j +: 8] <= mem[data_base + RAM_ADDR_WIDTH'(j)];
      end
    end
  end

  // byte-enabled write
  always_ff @(posedge clk_i) begin
    if (ram_req_i.req && ram_req_i.we) begin
      for (int k = 0; k < 4; k++) begin
        if (ram_req_i.be[k]) begin
          mem[data_base + RAM_ADDR_WIDTH'(k)] <= ram_req_i.wdata[8*k +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/data_decoder.sv
// ##############################
// every data request is granted in its own cycle
// unmapped reads and writes go to the error target
// ##############################

`timescale 1ns/1ps

module data_decoder #(
  parameter int RAM_ADDR_WIDTH = 16
) (
  input  logic                  data_req_i,
  input  logic                  data_we_i,
  input  logic [3:0]            data_be_i,
  input  logic [31:0]           data_addr_i,
  input  logic [31:0]           data_wdata_i,

  output mm_ram_pkg::ram_req_t  ram_req_o,
  output mm_ram_pkg::timer_wr_t timer_wr_o,
  output mm_ram_pkg::target_e   target_o,
  output logic                  data_gnt_o,

  output logic                  tests_passed_o,
  output logic                  tests_failed_o,
  output logic                  exit_valid_o,
  output logic [31:0]           exit_value_o
);

  // address hits
  logic ram_hit;
  logic mask_hit;
  logic cnt_hit;
  logic status_hit;
  logic exit_hit;
  logic periph_rd_hit;

  // accepted accesses split by direction
  logic wr_acc;
  logic rd_acc;
  logic wr_mapped;
  logic rd_mapped;

  // RAM covers every address below 2**RAM_ADDR_WIDTH
  assign ram_hit       = (data_addr_i >> RAM_ADDR_WIDTH) == 32'd0;
  assign mask_hit      = data_addr_i == mm_ram_pkg::TIMER_MASK_ADDR;
  assign cnt_hit       = data_addr_i == mm_ram_pkg::TIMER_CNT_ADDR;
  assign status_hit    = data_addr_i == mm_ram_pkg::STATUS_ADDR;
  assign exit_hit      = data_addr_i == mm_ram_pkg::EXIT_ADDR;
  assign periph_rd_hit = data_addr_i == mm_ram_pkg::PERIPH_RD_ADDR;

  assign wr_acc = data_req_i && data_we_i;
  assign rd_acc = data_req_i && !data_we_i;

  assign wr_mapped = ram_hit || mask_hit || cnt_hit || status_hit || exit_hit;
  assign rd_mapped = ram_hit || periph_rd_hit;

  // no back-pressure
  assign data_gnt_o = data_req_i;

  // target of the request, only sampled when a request is present
  always_comb begin
    target_o = mm_ram_pkg::TGT_PERIPH;
    if (data_req_i) begin
      if (ram_hit) begin
        target_o = mm_ram_pkg::TGT_RAM;
      end else if ((wr_acc && !wr_mapped) || (rd_acc && !rd_mapped)) begin
        target_o = mm_ram_pkg::TGT_ERR;
      end
    end
  end

  // RAM request, payload passes unchanged
  always_comb begin
    ram_req_o.req   = data_req_i && ram_hit;
    ram_req_o.we    = data_we_i;
    ram_req_o.be    = data_be_i;
    ram_req_o.addr  = data_addr_i;
    ram_req_o.wdata = data_wdata_i;
  end

  // timer register writes
  always_comb begin
    timer_wr_o.mask_we = wr_acc && mask_hit;
    timer_wr_o.cnt_we  = wr_acc && cnt_hit;
    timer_wr_o.wdata   = data_wdata_i;
  end

  // status pulses, any other value raises neither
  assign tests_passed_o = wr_acc && status_hit && (data_wdata_i == mm_ram_pkg::PASS_CODE);
  assign tests_failed_o = wr_acc && status_hit && (data_wdata_i == mm_ram_pkg::FAIL_CODE);

  // exit value is only driven while the write is present
  assign exit_valid_o = wr_acc && exit_hit;
  assign exit_value_o = exit_valid_o ? data_wdata_i : 32'd0;

endmodule

//--- hdl/sim_timer.sv
// ##############################
// any timer register write holds the count for that edge
// ##############################

`timescale 1ns/1ps

module sim_timer (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  mm_ram_pkg::timer_wr_t timer_wr_i,

  input  logic                  irq_ack_i,
  input  logic [4:0]            irq_id_i,
  output logic                  irq_timer_o
);

  logic [31:0] mask_q;
  logic [31:0] cnt_q;
  logic        irq_q;

  logic        count_en;
  logic        expire;
  logic        ack_hit;

  // count only on edges without a timer write
  assign count_en = !timer_wr_i.mask_we && !timer_wr_i.cnt_we && (cnt_q != 32'd0);

  // step from 1 to 0 fires when the mask bit is set
  assign expire  = count_en && (cnt_q == 32'd1) && mask_q[mm_ram_pkg::TIMER_IRQ_ID];
  assign ack_hit = irq_ack_i && (irq_id_i == mm_ram_pkg::TIMER_IRQ_ID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= 32'd0;
      cnt_q  <= 32'd0;
    end else begin
      if (timer_wr_i.mask_we) begin
        mask_q <= timer_wr_i.wdata;
      end
      if (timer_wr_i.cnt_we) begin
        cnt_q <= timer_wr_i.wdata;
      end else if (count_en) begin
        cnt_q <= cnt_q - 32'd1;
      end
    end
  end

  // interrupt is sticky until acknowledged, ack wins a tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else if (ack_hit) begin
      irq_q <= 1'b0;
    end else if (expire) begin
      irq_q <= 1'b1;
    end
  end

  assign irq_timer_o = irq_q;

endmodule

//--- hdl/response_stage.sv
// ##############################
// one response per accepted request, one cycle later
// read data is zero outside a RAM read response
// ##############################

`timescale 1ns/1ps

module response_stage #(
  parameter int INSTR_RDATA_WIDTH = 128
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // request side, grant equals request on both ports
  input  logic                         instr_req_i,
  input  logic                         data_req_i,
  input  logic                         data_we_i,
  input  mm_ram_pkg::target_e          target_i,

  // registered words from the RAM
  input  logic [INSTR_RDATA_WIDTH-1:0] instr_ram_rdata_i,
  input  logic [31:0]                  data_ram_rdata_i,

  output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
  output logic                         instr_rvalid_o,
  output logic [31:0]                  data_rdata_o,
  output logic                         data_rvalid_o,
  output logic                         data_err_o
);

  logic                instr_rvalid_q;
  logic                data_rvalid_q;
  logic                data_read_q;
  mm_ram_pkg::target_e target_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_q <= 1'b0;
      data_rvalid_q  <= 1'b0;
      data_read_q    <= 1'b0;
      target_q       <= mm_ram_pkg::TGT_RAM;
    end else begin
      instr_rvalid_q <= instr_req_i;
      data_rvalid_q  <= data_req_i;
      data_read_q    <= data_req_i && !data_we_i;
      target_q       <= target_i;
    end
  end

  assign instr_rvalid_o = instr_rvalid_q;
  assign instr_rdata_o  = instr_rvalid_q ? instr_ram_rdata_i : '0;

  // writes and peripheral reads return zero
  assign data_rvalid_o = data_rvalid_q;
  assign data_rdata_o  = (data_read_q && target_q == mm_ram_pkg::TGT_RAM) ?
                         data_ram_rdata_i : 32'd0;
  assign data_err_o    = data_rvalid_q && (target_q == mm_ram_pkg::TGT_ERR);

endmodule

//--- hdl/mm_ram.sv
// ##############################
// RAM wrapper on a req/gnt/rvalid bus, never stalls
// INSTR_RDATA_WIDTH must be a multiple of 32
// ##############################

`timescale 1ns/1ps

module mm_ram #(
  parameter int RAM_ADDR_WIDTH    = 16,
  parameter int INSTR_RDATA_WIDTH = 128
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // instruction port
  input  logic                         instr_req_i,
  input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
  output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,
  output logic                         instr_rvalid_o,
  output logic                         instr_gnt_o,

  // data port
  input  logic                         data_req_i,
  input  logic                         data_we_i,
  input  logic [3:0]                   data_be_i,
  input  logic [31:0]                  data_addr_i,
  input  logic [31:0]                  data_wdata_i,
  output logic [31:0]                  data_rdata_o,
  output logic                         data_rvalid_o,
  output logic                         data_gnt_o,
  output logic                         data_err_o,

  // interrupt
  input  logic                         irq_ack_i,
  input  logic [4:0]                   irq_id_i,
  output logic                         irq_timer_o,

  // test control
  output logic                         tests_passed_o,
  output logic                         tests_failed_o,
  output logic                         exit_valid_o,
  output logic [31:0]                  exit_value_o
);

  mm_ram_pkg::ram_req_t         ram_req;
  mm_ram_pkg::timer_wr_t        timer_wr;
  mm_ram_pkg::target_e          target;
  logic [INSTR_RDATA_WIDTH-1:0] instr_ram_rdata;
  logic [31:0]                  data_ram_rdata;

  // fetches are always granted at once
  assign instr_gnt_o = instr_req_i;

  data_decoder #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) u_data_decoder (
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .ram_req_o      (ram_req),
    .timer_wr_o     (timer_wr),
    .target_o       (target),
    .data_gnt_o     (data_gnt_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

  dp_ram #(
    .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
    .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
  ) u_dp_ram (
    .clk_i         (clk_i),
    .instr_req_i   (instr_req_i),
    .instr_addr_i  (instr_addr_i),
    .instr_rdata_o (instr_ram_rdata),
    .ram_req_i     (ram_req),
    .data_rdata_o  (data_ram_rdata)
  );

  sim_timer u_sim_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .timer_wr_i  (timer_wr),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .irq_timer_o (irq_timer_o)
  );

  response_stage #(
    .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
  ) u_response_stage (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_req_i       (instr_req_i),
    .data_req_i        (data_req_i),
    .data_we_i         (data_we_i),
    .target_i          (target),
    .instr_ram_rdata_i (instr_ram_rdata),
    .data_ram_rdata_i  (data_ram_rdata),
    .instr_rdata_o     (instr_rdata_o),
    .instr_rvalid_o    (instr_rvalid_o),
    .data_rdata_o      (data_rdata_o),
    .data_rvalid_o     (data_rvalid_o),
    .data_err_o        (data_err_o)
  );

endmodule

//--- testbench/tb_mm_ram.sv
// ##############################
// RAM model only tracks bytes 0..255 and the top 16 bytes of the array
// ##############################

`timescale 1ns/1ps

module tb_mm_ram;

  localparam int RAM_ADDR_WIDTH    = 16;
  localparam int INSTR_RDATA_WIDTH = 128;
  localparam int INSTR_BYTES       = INSTR_RDATA_WIDTH / 8;
  localparam int CLK_PERIOD        = 20;
  localparam int RESET_CYCLES      = 5;
  localparam int FILL_WORDS        = 64;
  localparam int NUM_RAND_OPS      = 1200;
  localparam int NUM_FETCHES       = 300;
  // all tests take about 1700 cycles and the limit leaves twice that
  localparam int TIMEOUT_CYCLES    = 4000;
  localparam logic [31:0] RAM_TOP  = 32'(2 ** RAM_ADDR_WIDTH);

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } data_rsp_t;

  logic                         clk;
  logic                         rst_n;
  logic                         instr_req;
  logic [RAM_ADDR_WIDTH-1:0]    instr_addr;
  logic [INSTR_RDATA_WIDTH-1:0] instr_rdata;
  logic                         instr_rvalid;
  logic                         instr_gnt;
  logic                         data_req;
  logic                         data_we;
  logic [3:0]                   data_be;
  logic [31:0]                  data_addr;
  logic [31:0]                  data_wdata;
  logic [31:0]                  data_rdata;
  logic                         data_rvalid;
  logic                         data_gnt;
  logic                         data_err;
  logic                         irq_ack;
  logic [4:0]                   irq_id;
  logic                         irq_timer;
  logic                         tests_passed;
  logic                         tests_failed;
  logic                         exit_valid;
  logic [31:0]                  exit_value;

  integer seed;
  int     cycle_cnt = 0;

  // reference state
  logic [7:0]                   ref_mem [0:2**RAM_ADDR_WIDTH-1];
  logic [31:0]                  ref_mask;
  logic [31:0]                  ref_cnt;
  logic                         ref_irq;
  data_rsp_t                    data_exp_q [$];
  logic [INSTR_RDATA_WIDTH-1:0] instr_exp_q [$];

  mm_ram dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_rdata_o  (instr_rdata),
    .instr_rvalid_o (instr_rvalid),
    .instr_gnt_o    (instr_gnt),
    .data_req_i     (data_req),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_rdata_o   (data_rdata),
    .data_rvalid_o  (data_rvalid),
    .data_gnt_o     (data_gnt),
    .data_err_o     (data_err),
    .irq_ack_i      (irq_ack),
    .irq_id_i       (irq_id),
    .irq_timer_o    (irq_timer),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic mismatch_fail(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // responses are due one edge after acceptance and new requests queue up here
  always @(posedge clk) begin
    data_rsp_t                    rsp;
    logic [INSTR_RDATA_WIDTH-1:0] exp_instr;
    logic [RAM_ADDR_WIDTH-1:0]    base;
    logic                         wr;
    logic                         exp_exit;
    logic                         exp_pass;
    logic                         exp_fail;
    logic                         expire;
    if (!rst_n) begin
      data_exp_q.delete();
      instr_exp_q.delete();
      ref_mask = '0;
      ref_cnt  = '0;
      ref_irq  = 1'b0;
    end else begin
      assert (data_rvalid == (data_exp_q.size() != 0))
        else mismatch_fail("data_rvalid_o", 128'(data_rvalid), 128'(data_exp_q.size() != 0));
      if (data_exp_q.size() != 0) begin
        rsp = data_exp_q.pop_front();
        assert (data_rdata == rsp.rdata)
          else mismatch_fail("data_rdata_o", 128'(data_rdata), 128'(rsp.rdata));
        assert (data_err == rsp.err)
          else mismatch_fail("data_err_o", 128'(data_err), 128'(rsp.err));
      end
      assert (instr_rvalid == (instr_exp_q.size() != 0))
        else mismatch_fail("instr_rvalid_o", 128'(instr_rvalid), 128'(instr_exp_q.size() != 0));
      if (instr_exp_q.size() != 0) begin
        exp_instr = instr_exp_q.pop_front();
        assert (instr_rdata == exp_instr)
          else mismatch_fail("instr_rdata_o", instr_rdata, exp_instr);
      end

      // grants and status outputs are combinational
      wr       = data_req && data_we;
      exp_exit = wr && (data_addr == mm_ram_pkg::EXIT_ADDR);
      exp_pass = wr && data_addr == mm_ram_pkg::STATUS_ADDR &&
                 data_wdata == mm_ram_pkg::PASS_CODE;
      exp_fail = wr && data_addr == mm_ram_pkg::STATUS_ADDR &&
                 data_wdata == mm_ram_pkg::FAIL_CODE;
      assert (data_gnt == data_req)
        else mismatch_fail("data_gnt_o", 128'(data_gnt), 128'(data_req));
      assert (instr_gnt == instr_req)
        else mismatch_fail("instr_gnt_o", 128'(instr_gnt), 128'(instr_req));
      assert (tests_passed == exp_pass)
        else mismatch_fail("tests_passed_o", 128'(tests_passed), 128'(exp_pass));
      assert (tests_failed == exp_fail)
        else mismatch_fail("tests_failed_o", 128'(tests_failed), 128'(exp_fail));
      assert (exit_valid == exp_exit)
        else mismatch_fail("exit_valid_o", 128'(exit_valid), 128'(exp_exit));
      assert (exit_value == (exp_exit ? data_wdata : 32'd0))
        else mismatch_fail("exit_value_o", 128'(exit_value), 128'(exp_exit ? data_wdata : 32'd0));
      assert (irq_timer == ref_irq)
        else mismatch_fail("irq_timer_o", 128'(irq_timer), 128'(ref_irq));

      // fetch reads the bytes before any write of this edge
      if (instr_req) begin
        base = {instr_addr[RAM_ADDR_WIDTH-1:2], 2'b00};
        for (int i = 0; i < INSTR_BYTES; i++) begin
          exp_instr[8*i +: 8] = ref_mem[base + RAM_ADDR_WIDTH'(i)];
        end
        instr_exp_q.push_back(exp_instr);
      end
      if (data_req) begin
        rsp = '0;
        if (data_addr < RAM_TOP) begin
          base = {data_addr[RAM_ADDR_WIDTH-1:2], 2'b00};
          for (int j = 0; j < 4; j++) begin
            if (!data_we) begin
              rsp.rdata[8*j +: 8] = ref_mem[base + RAM_ADDR_WIDTH'(j)];
            end else if (data_be[j]) begin
              ref_mem[base + RAM_ADDR_WIDTH'(j)] = data_wdata[8*j +: 8];
            end
          end
        end else if (data_we) begin
          rsp.err = !(data_addr == mm_ram_pkg::TIMER_MASK_ADDR ||
                      data_addr == mm_ram_pkg::TIMER_CNT_ADDR ||
                      data_addr == mm_ram_pkg::STATUS_ADDR || exp_exit);
        end else begin
          rsp.err = data_addr != mm_ram_pkg::PERIPH_RD_ADDR;
        end
        data_exp_q.push_back(rsp);
      end

      // the count steps down only on edges without a timer register write
      expire = 1'b0;
      if (wr && data_addr == mm_ram_pkg::TIMER_MASK_ADDR) begin
        ref_mask = data_wdata;
      end else if (wr && data_addr == mm_ram_pkg::TIMER_CNT_ADDR) begin
        ref_cnt = data_wdata;
      end else if (ref_cnt != 32'd0) begin
        expire  = (ref_cnt == 32'd1) && ref_mask[mm_ram_pkg::TIMER_IRQ_ID];
        ref_cnt = ref_cnt - 32'd1;
      end
      if (irq_ack && irq_id == mm_ram_pkg::TIMER_IRQ_ID) begin
        ref_irq = 1'b0;
      end else if (expire) begin
        ref_irq = 1'b1;
      end
    end
  end

  // drives one bus cycle on the falling edge
  task automatic drive_cycle(input logic req, input logic we, input logic [3:0] be,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic ireq, input logic [RAM_ADDR_WIDTH-1:0] iaddr);
    @(negedge clk);
    data_req   = req;
    data_we    = we;
    data_be    = be;
    data_addr  = addr;
    data_wdata = wdata;
    instr_req  = ireq;
    instr_addr = iaddr;
    irq_ack    = 1'b0;
    irq_id     = '0;
  endtask

  task automatic bus_idle();
    drive_cycle(1'b0, 1'b0, 4'h0, '0, '0, 1'b0, '0);
  endtask

  task automatic pulse_ack(input logic [4:0] id);
    @(negedge clk);
    data_req  = 1'b0;
    instr_req = 1'b0;
    irq_ack   = 1'b1;
    irq_id    = id;
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {~addr[15:0], addr[31:16] ^ addr[15:0]} ^ 32'h5a3c_96e1;
  endfunction

  // fills the low window and the top 16 bytes so wrapping fetches see known data
  task automatic fill_ram();
    logic [31:0] a;
    for (int w = 0; w < FILL_WORDS + 4; w++) begin
      a = (w < FILL_WORDS) ? 32'(4 * w) : RAM_TOP - 32'(4 * (FILL_WORDS + 4 - w));
      drive_cycle(1'b1, 1'b1, 4'hF, a, fill_word(a), 1'b0, '0);
    end
    bus_idle();
  endtask

  task automatic random_ram_ops(input int n);
    logic [31:0] r;
    logic [31:0] d;
    for (int k = 0; k < n; k++) begin
      r = $random(seed);
      d = $random(seed);
      drive_cycle(|r[3:2], r[0], r[7:4], {24'd0, r[15:8]}, d,
                  r[1], {9'd0, r[22:16]});
    end
    bus_idle();
  endtask

  // some fetches share their cycle with a data write and the last two wrap
  task automatic fetch_sweep(input int n);
    logic [31:0] r;
    logic [31:0] d;
    for (int k = 0; k < n; k++) begin
      r = $random(seed);
      d = $random(seed);
      drive_cycle(r[8], 1'b1, 4'hF, {24'd0, d[7:2], 2'b00}, d,
                  1'b1, {8'd0, r[7:0] % 8'd240});
    end
    drive_cycle(1'b0, 1'b0, 4'h0, '0, '0, 1'b1, 16'hFFF8);
    drive_cycle(1'b0, 1'b0, 4'h0, '0, '0, 1'b1, 16'hFFF5);
    bus_idle();
  endtask

  task automatic status_writes();
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::STATUS_ADDR, mm_ram_pkg::PASS_CODE, 1'b0, '0);
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::STATUS_ADDR, mm_ram_pkg::FAIL_CODE, 1'b0, '0);
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::STATUS_ADDR, 32'hdead_beef, 1'b0, '0);
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::EXIT_ADDR, 32'h0000_002a, 1'b0, '0);
    bus_idle();
    bus_idle();
  endtask

  task automatic timer_check(input logic [31:0] mask, input logic [31:0] count);
    int edges;
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::TIMER_MASK_ADDR, mask, 1'b0, '0);
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::TIMER_CNT_ADDR, count, 1'b0, '0);
    bus_idle();
    // edges counts the rising edges since the load edge
    edges = 0;
    while (!irq_timer && edges < int'(count) + 3) begin
      @(negedge clk);
      edges++;
    end
    if (mask[mm_ram_pkg::TIMER_IRQ_ID]) begin
      assert (irq_timer && edges == int'(count))
        else mismatch_fail("irq_timer_o rise edge", 128'(edges), 128'(count));
      pulse_ack(5'd3);
      bus_idle();
      assert (irq_timer) else mismatch_fail("irq_timer_o", 128'(irq_timer), 128'(1));
      pulse_ack(mm_ram_pkg::TIMER_IRQ_ID);
      bus_idle();
      assert (!irq_timer) else mismatch_fail("irq_timer_o", 128'(irq_timer), 128'(0));
    end else begin
      assert (!irq_timer) else mismatch_fail("irq_timer_o", 128'(irq_timer), 128'(0));
    end
  endtask

  task automatic unmapped_access();
    drive_cycle(1'b1, 1'b1, 4'hF, 32'h3000_0010, 32'h1234_5678, 1'b0, '0);
    drive_cycle(1'b1, 1'b0, 4'hF, 32'h3000_0010, '0, 1'b0, '0);
    drive_cycle(1'b1, 1'b0, 4'hF, RAM_TOP, '0, 1'b0, '0);
    drive_cycle(1'b1, 1'b0, 4'hF, mm_ram_pkg::TIMER_CNT_ADDR, '0, 1'b0, '0);
    drive_cycle(1'b1, 1'b0, 4'hF, mm_ram_pkg::PERIPH_RD_ADDR, '0, 1'b0, '0);
    drive_cycle(1'b1, 1'b1, 4'hF, mm_ram_pkg::PERIPH_RD_ADDR, 32'h0000_00ff, 1'b0, '0);
    bus_idle();
  endtask

  initial begin
    logic [31:0] r;
    seed       = 32'h914e;
    rst_n      = 1'b0;
    instr_req  = 1'b0;
    instr_addr = '0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    data_be    = '0;
    data_addr  = '0;
    data_wdata = '0;
    irq_ack    = 1'b0;
    irq_id     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert ({instr_rvalid, instr_gnt, data_rvalid, data_gnt, data_err, irq_timer,
             tests_passed, tests_failed, exit_valid, exit_value} == '0)
      else mismatch_fail("control outputs after reset", 128'({instr_rvalid, instr_gnt,
                         data_rvalid, data_gnt, data_err, irq_timer, tests_passed,
                         tests_failed, exit_valid, exit_value}), 128'(0));
    fill_ram();
    random_ram_ops(NUM_RAND_OPS);
    fetch_sweep(NUM_FETCHES);
    status_writes();
    r = $random(seed);
    timer_check(32'h0000_0080, 32'd1);
    timer_check(32'h0000_0080, 32'd5 + {27'd0, r[4:0]});
    timer_check(32'hffff_ff7f, 32'd6);
    unmapped_access();
    repeat (3) bus_idle();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- mm_ram.f
hdl/mm_ram_pkg.sv
hdl/dp_ram.sv
hdl/data_decoder.sv
hdl/sim_timer.sv
hdl/response_stage.sv
hdl/mm_ram.sv
testbench/tb_mm_ram.sv

//--- run_sim.sh
#!/bin/sh
# Builds tb_mm_ram with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
EXE=Vtb_mm_ram

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mm_ram \
  --Mdir "$BUILD_DIR" -o "$EXE" \
  -f mm_ram.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
